// File: hw/mmio_pkg.sv
// MMIO address map
`default_nettype none

package mmio_pkg;

    // CPU side widths
    localparam int DATA_W = 16;
    localparam int ADDR_W = 16;

    // Peripheral side width
    localparam int BYTE_W = 8;

    // I/O window at the top of memory
    localparam logic [ADDR_W-1:0] IO_BASE = 16'hff00;

    // Byte addresses inside the window
    localparam logic [ADDR_W-1:0] LED_ADDR         = 16'hff00;
    localparam logic [ADDR_W-1:0] UART_DATA_ADDR   = 16'hff02;
    localparam logic [ADDR_W-1:0] UART_STATUS_ADDR = 16'hff03;

    // Kind of access presented by the CPU in one cycle
    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_READ,
        ACC_WRITE
    } access_e;

endpackage

`default_nettype wire

// File: hw/uart_pkg.sv
// UART definitions
`default_nettype none

package uart_pkg;

    // Baud timing and 8N1 framing
    localparam int CLKS_PER_BIT = 16;
    localparam int FRAME_BITS   = 10;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Status byte layout, upper bits read as zero
    localparam int STAT_RX_VALID   = 0;
    localparam int STAT_TX_BUSY    = 1;
    localparam int STAT_RX_OVERRUN = 2;
    localparam int STAT_FRAME_ERR  = 3;

endpackage

`default_nettype wire

// File: hw/periph_if.sv
// Peripheral access interface
`timescale 1ns/1ps
`default_nettype none

interface periph_if;

    // Single-cycle strobes from the decoder
    logic wr;
    logic rd;

    logic [mmio_pkg::BYTE_W-1:0] wdata;
    logic [mmio_pkg::BYTE_W-1:0] rdata;

    modport host (
        output wr,
        output rd,
        output wdata,
        input  rdata
    );

    modport dev (
        input  wr,
        input  rd,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: hw/led_port.sv
// LED output port
`timescale 1ns/1ps
`default_nettype none

module led_port (
    input  logic                        clk,
    input  logic                        arst_n,
    periph_if.dev                       bus,
    output logic [mmio_pkg::BYTE_W-1:0] led_out
);

    logic [mmio_pkg::BYTE_W-1:0] led_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led_reg <= '0;
        end else if (bus.wr) begin
            led_reg <= bus.wdata;
        end
    end

    // Pins and readback share the register
    assign led_out   = led_reg;
    assign bus.rdata = led_reg;

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// UART transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [mmio_pkg::BYTE_W-1:0] data,
    output logic                        busy,
    output logic                        tx
);

    uart_pkg::tx_state_e state;

    logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] bit_timer;
    logic [$clog2(uart_pkg::FRAME_BITS-2)-1:0] bit_idx;
    logic [mmio_pkg::BYTE_W-1:0]               shreg;
    logic                                      bit_end;

    assign bit_end = (bit_timer == uart_pkg::CLKS_PER_BIT - 1);
    assign busy    = (state != uart_pkg::TX_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= uart_pkg::TX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    bit_timer <= '0;
                    if (start) begin
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    bit_timer <= bit_timer + 1'b1;
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                    end
                end
                uart_pkg::TX_DATA: begin
                    bit_timer <= bit_timer + 1'b1;
                    if (bit_end) begin
                        if (bit_idx == uart_pkg::FRAME_BITS - 3) begin
                            state <= uart_pkg::TX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    bit_timer <= bit_timer + 1'b1;
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::TX_IDLE && start) begin
            shreg <= data;
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    // Registered line, one cycle behind the state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_START: tx <= 1'b0;
                uart_pkg::TX_DATA:  tx <= shreg[0];
                default:            tx <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
// UART receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        rx,
    output logic [mmio_pkg::BYTE_W-1:0] data,
    output logic                        done,
    output logic                        frame_err
);

    uart_pkg::rx_state_e state;

    logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0] bit_timer;
    logic [$clog2(uart_pkg::FRAME_BITS-2)-1:0] bit_idx;
    logic [mmio_pkg::BYTE_W-1:0]               shreg;
    logic                                      rx_meta;
    logic                                      rx_sync;
    logic                                      rx_prev;
    logic                                      bit_end;

    // Two-flop synchronizer plus a history bit for edge detection
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign bit_end = (bit_timer == uart_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= uart_pkg::RX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    bit_timer <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    bit_timer <= bit_timer + 1'b1;
                    // Middle of the start bit, a glitch returns to idle
                    if (bit_timer == uart_pkg::CLKS_PER_BIT / 2 - 1) begin
                        bit_timer <= '0;
                        bit_idx   <= '0;
                        state     <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    bit_timer <= bit_timer + 1'b1;
                    if (bit_end) begin
                        if (bit_idx == uart_pkg::FRAME_BITS - 3) begin
                            state <= uart_pkg::RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    bit_timer <= bit_timer + 1'b1;
                    if (bit_end) begin
                        done      <= 1'b1;
                        frame_err <= !rx_sync;
                        state     <= uart_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            shreg <= {rx_sync, shreg[mmio_pkg::BYTE_W-1:1]};
        end
    end

    assign data = shreg;

endmodule

`default_nettype wire

// File: hw/uart_controller.sv
// UART register block
`timescale 1ns/1ps
`default_nettype none

module uart_controller (
    input  logic                        clk,
    input  logic                        arst_n,
    periph_if.dev                       bus,
    output logic [mmio_pkg::BYTE_W-1:0] status,
    input  logic                        rx,
    output logic                        tx
);

    logic                        tx_busy;
    logic                        tx_start;
    logic [mmio_pkg::BYTE_W-1:0] rx_byte;
    logic                        rx_done;
    logic                        rx_ferr;
    logic [mmio_pkg::BYTE_W-1:0] rx_data;
    logic                        rx_valid;
    logic                        rx_overrun;
    logic                        frame_err;

    // Writes while a frame is in flight are dropped
    assign tx_start = bus.wr && !tx_busy;

    uart_tx u_tx (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (tx_start),
        .data   (bus.wdata),
        .busy   (tx_busy),
        .tx     (tx)
    );

    uart_rx u_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .data      (rx_byte),
        .done      (rx_done),
        .frame_err (rx_ferr)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_data    <= '0;
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (bus.rd) begin
                rx_valid   <= 1'b0;
                rx_overrun <= 1'b0;
                frame_err  <= 1'b0;
            end
            // A new byte wins over a read in the same cycle
            if (rx_done) begin
                rx_data  <= rx_byte;
                rx_valid <= 1'b1;
                if (rx_valid && !bus.rd) begin
                    rx_overrun <= 1'b1;
                end
                if (rx_ferr) begin
                    frame_err <= 1'b1;
                end
            end
        end
    end

    assign bus.rdata = rx_data;

    always_comb begin
        status                            = '0;
        status[uart_pkg::STAT_RX_VALID]   = rx_valid;
        status[uart_pkg::STAT_TX_BUSY]    = tx_busy;
        status[uart_pkg::STAT_RX_OVERRUN] = rx_overrun;
        status[uart_pkg::STAT_FRAME_ERR]  = frame_err;
    end

    // Busy only ever rises from an accepted write
    a_busy_from_write: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(tx_busy) |-> $past(bus.wr));

    // Start bit appears on the line the edge after busy
    a_start_bit: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |=> tx_busy ##1 !tx);

endmodule

`default_nettype wire

// File: hw/mmio.sv
// Memory-mapped I/O block
`timescale 1ns/1ps
`default_nettype none

module mmio (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        en,
    input  logic                        write_enable,
    input  logic                        byte_select,
    input  logic                        byte_enable,
    input  logic [mmio_pkg::ADDR_W-1:0] addr,
    input  logic [mmio_pkg::DATA_W-1:0] data_in,
    output logic [mmio_pkg::DATA_W-1:0] data_out,
    output logic                        serviced_read,
    output logic [mmio_pkg::BYTE_W-1:0] led_out,
    input  logic                        rx,
    output logic                        tx
);

    mmio_pkg::access_e           acc;
    logic [mmio_pkg::ADDR_W-1:0] byte_addr;
    logic [mmio_pkg::BYTE_W-1:0] uart_status;
    logic [mmio_pkg::BYTE_W-1:0] rd_byte;

    periph_if led_if ();
    periph_if uart_if ();

    // Word address to byte address, bit 15 dropped
    assign byte_addr = {addr[14:0], byte_enable ? byte_select : 1'b0};

    assign acc = !en          ? mmio_pkg::ACC_NONE  :
                 write_enable ? mmio_pkg::ACC_WRITE : mmio_pkg::ACC_READ;

    assign led_if.wr    = (acc == mmio_pkg::ACC_WRITE) && (byte_addr == mmio_pkg::LED_ADDR);
    assign led_if.rd    = (acc == mmio_pkg::ACC_READ) && (byte_addr == mmio_pkg::LED_ADDR);
    assign led_if.wdata = data_in[mmio_pkg::BYTE_W-1:0];

    assign uart_if.wr    = (acc == mmio_pkg::ACC_WRITE) &&
                           (byte_addr == mmio_pkg::UART_DATA_ADDR);
    assign uart_if.rd    = (acc == mmio_pkg::ACC_READ) &&
                           (byte_addr == mmio_pkg::UART_DATA_ADDR);
    assign uart_if.wdata = data_in[mmio_pkg::BYTE_W-1:0];

    led_port u_led (
        .clk     (clk),
        .arst_n  (arst_n),
        .bus     (led_if),
        .led_out (led_out)
    );

    uart_controller u_uart (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (uart_if),
        .status (uart_status),
        .rx     (rx),
        .tx     (tx)
    );

    always_comb begin
        case (byte_addr)
            mmio_pkg::LED_ADDR:         rd_byte = led_if.rdata;
            mmio_pkg::UART_DATA_ADDR:   rd_byte = uart_if.rdata;
            mmio_pkg::UART_STATUS_ADDR: rd_byte = uart_status;
            default:                    rd_byte = '0;
        endcase
    end

    // Read data holds between reads
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out      <= '0;
            serviced_read <= 1'b0;
        end else begin
            serviced_read <= (acc == mmio_pkg::ACC_READ) && (byte_addr >= mmio_pkg::IO_BASE);
            if (acc == mmio_pkg::ACC_READ) begin
                data_out <= {{(mmio_pkg::DATA_W - mmio_pkg::BYTE_W){1'b0}}, rd_byte};
            end
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({led_if.wr, led_if.rd, uart_if.wr, uart_if.rd}));

    a_read_follows_request: assert property (@(posedge clk) disable iff (!arst_n)
        serviced_read |-> $past(en && !write_enable));

endmodule

`default_nettype wire

// File: dv/mmio_tb.sv
// MMIO block testbench
`timescale 1ns/1ps
`default_nettype none

module mmio_tb;

    localparam int RESET_CYCLES = 16;
    // Six UART frames of 160 cycles with room for polling
    localparam int MAX_CYCLES = 6000;
    localparam logic [15:0] ST_VALID = 16'd1 << uart_pkg::STAT_RX_VALID;
    localparam logic [15:0] ST_BUSY  = 16'd1 << uart_pkg::STAT_TX_BUSY;
    localparam logic [15:0] ST_OVR   = 16'd1 << uart_pkg::STAT_RX_OVERRUN;
    localparam logic [15:0] ST_FERR  = 16'd1 << uart_pkg::STAT_FRAME_ERR;

    logic        clk;
    logic        arst_n;
    logic        en;
    logic        write_enable;
    logic        byte_select;
    logic        byte_enable;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        serviced_read;
    logic [7:0]  led_out;
    logic        rx;
    logic        tx;
    logic        use_gen;
    logic        gen_rx;
    logic [7:0]  last_rx;
    integer      seed;
    int          errors;
    int          cycles = 0;

    // tx loops back to rx unless the frame generator owns the line
    assign rx = use_gen ? gen_rx : tx;

    mmio UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .en            (en),
        .write_enable  (write_enable),
        .byte_select   (byte_select),
        .byte_enable   (byte_enable),
        .addr          (addr),
        .data_in       (data_in),
        .data_out      (data_out),
        .serviced_read (serviced_read),
        .led_out       (led_out),
        .rx            (rx),
        .tx            (tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a test never finished", cycles);
            $display("Done: errors found");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "Check failed");
        end
    endtask

    // Word address that carries a byte address, bit 15 left clear
    function automatic logic [15:0] word_of(input logic [15:0] baddr);
        return {1'b0, baddr[15:1]};
    endfunction

    task automatic bus_write(input logic [15:0] waddr, input logic be, input logic bs,
                             input logic [15:0] wdata);
        @(posedge clk);
        en           <= 1'b1;
        write_enable <= 1'b1;
        addr         <= waddr;
        byte_enable  <= be;
        byte_select  <= bs;
        data_in      <= wdata;
        @(posedge clk);
        en           <= 1'b0;
        write_enable <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] waddr, input logic be, input logic bs,
                            output logic [15:0] rdata, output logic srv);
        @(posedge clk);
        en           <= 1'b1;
        write_enable <= 1'b0;
        addr         <= waddr;
        byte_enable  <= be;
        byte_select  <= bs;
        @(posedge clk);
        en <= 1'b0;
        // Registered outputs settle well before the falling edge
        @(negedge clk);
        rdata = data_out;
        srv   = serviced_read;
    endtask

    task automatic write_byte(input logic [15:0] baddr, input logic [15:0] wdata);
        bus_write(word_of(baddr), 1'b1, baddr[0], wdata);
    endtask

    task automatic read_byte(input logic [15:0] baddr, output logic [15:0] rdata,
                             output logic srv);
        bus_read(word_of(baddr), 1'b1, baddr[0], rdata, srv);
    endtask

    task automatic expect_read(input string name, input logic [15:0] baddr,
                               input logic [15:0] exp);
        logic [15:0] d;
        logic        s;
        read_byte(baddr, d, s);
        check_value(name, d, exp);
        check_value("serviced_read", 16'(s), 16'd1);
    endtask

    // Polls the status register until the masked bits match
    task automatic wait_status(input logic [15:0] mask, input logic [15:0] value);
        logic [15:0] st;
        logic        s;
        read_byte(mmio_pkg::UART_STATUS_ADDR, st, s);
        while ((st & mask) != value) begin
            read_byte(mmio_pkg::UART_STATUS_ADDR, st, s);
        end
    endtask

    task automatic test_led_path();
        logic [15:0] wdata;
        wdata = 16'($random(seed));
        write_byte(mmio_pkg::LED_ADDR, wdata);
        @(negedge clk);
        check_value("led_out", {8'h00, led_out}, {8'h00, wdata[7:0]});
        expect_read("data_out led", mmio_pkg::LED_ADDR, {8'h00, wdata[7:0]});
    endtask

    task automatic test_loopback();
        logic [7:0]  val;
        logic [15:0] d;
        logic        s;
        val = 8'($random(seed));
        write_byte(mmio_pkg::UART_DATA_ADDR, {8'h00, val});
        wait_status(ST_VALID, ST_VALID);
        expect_read("data_out uart data", mmio_pkg::UART_DATA_ADDR, {8'h00, val});
        read_byte(mmio_pkg::UART_STATUS_ADDR, d, s);
        check_value("status rx_valid", d & ST_VALID, 16'h0000);
        last_rx = val;
        wait_status(16'hffff, 16'h0000);
    endtask

    task automatic test_address_forming();
        logic [7:0]  val;
        logic [7:0]  old_led;
        logic [15:0] old_out;
        logic [15:0] d;
        logic        s;
        val = 8'($random(seed));
        // byte_select is ignored while byte_enable is low
        bus_write(word_of(mmio_pkg::UART_DATA_ADDR), 1'b0, 1'b1, {8'h00, val});
        // Bit 15 of the word address plays no part
        bus_read(word_of(mmio_pkg::UART_STATUS_ADDR) | 16'h8000, 1'b1, 1'b1, d, s);
        check_value("data_out status", d, ST_BUSY);
        check_value("serviced_read", 16'(s), 16'd1);
        bus_read(word_of(mmio_pkg::UART_STATUS_ADDR), 1'b1, 1'b0, d, s);
        check_value("data_out uart data", d, {8'h00, last_rx});
        wait_status(ST_VALID, ST_VALID);
        bus_read(word_of(mmio_pkg::UART_DATA_ADDR), 1'b0, 1'b0, d, s);
        check_value("data_out uart data", d, {8'h00, val});
        last_rx = val;
        expect_read("data_out unmapped", 16'hff04, 16'h0000);
        // Nonzero LED value so a stray read would show on data_out
        write_byte(mmio_pkg::LED_ADDR, {8'h00, val | 8'h01});
        read_byte(16'h1234, d, s);
        check_value("data_out below window", d, 16'h0000);
        check_value("serviced_read", 16'(s), 16'd0);
        old_led = led_out;
        old_out = data_out;
        @(posedge clk);
        en           <= 1'b0;
        write_enable <= 1'b1;
        addr         <= word_of(mmio_pkg::LED_ADDR);
        byte_enable  <= 1'b0;
        data_in      <= {8'h00, ~old_led};
        @(posedge clk);
        // Same address as a read, still without en
        write_enable <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("led_out", {8'h00, led_out}, {8'h00, old_led});
        check_value("data_out", data_out, old_out);
        check_value("serviced_read", 16'(serviced_read), 16'd0);
        wait_status(16'hffff, 16'h0000);
    endtask

    task automatic test_busy_rule();
        logic [7:0] first;
        first = 8'($random(seed));
        write_byte(mmio_pkg::UART_DATA_ADDR, {8'h00, first});
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, ST_BUSY);
        write_byte(mmio_pkg::UART_DATA_ADDR, {8'h00, ~first});
        wait_status(ST_VALID, ST_VALID);
        expect_read("data_out uart data", mmio_pkg::UART_DATA_ADDR, {8'h00, first});
        wait_status(ST_BUSY, 16'h0000);
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, 16'h0000);
    endtask

    task automatic test_overrun();
        logic [7:0] a;
        logic [7:0] b;
        a = 8'($random(seed));
        b = 8'($random(seed));
        write_byte(mmio_pkg::UART_DATA_ADDR, {8'h00, a});
        wait_status(ST_BUSY, 16'h0000);
        write_byte(mmio_pkg::UART_DATA_ADDR, {8'h00, b});
        wait_status(ST_OVR, ST_OVR);
        wait_status(ST_BUSY, 16'h0000);
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, ST_VALID | ST_OVR);
        expect_read("data_out uart data", mmio_pkg::UART_DATA_ADDR, {8'h00, b});
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, 16'h0000);
    endtask

    task automatic test_frame_error();
        logic [7:0] val;
        logic       bitv;
        val = 8'($random(seed));
        @(posedge clk);
        use_gen <= 1'b1;
        // Start bit, eight data bits LSB first, then a stop bit held low
        for (int i = 0; i < uart_pkg::FRAME_BITS; i++) begin
            bitv = (i == 0 || i == uart_pkg::FRAME_BITS - 1) ? 1'b0 : val[i-1];
            gen_rx <= bitv;
            repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
        end
        gen_rx <= 1'b1;
        wait_status(ST_FERR, ST_FERR);
        @(posedge clk);
        use_gen <= 1'b0;
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, ST_VALID | ST_FERR);
        expect_read("data_out uart data", mmio_pkg::UART_DATA_ADDR, {8'h00, val});
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, 16'h0000);
    endtask

    initial begin
        seed         = 91828;
        errors       = 0;
        arst_n       = 1'b0;
        en           = 1'b0;
        write_enable = 1'b0;
        byte_select  = 1'b0;
        byte_enable  = 1'b0;
        addr         = 16'h0000;
        data_in      = 16'h0000;
        use_gen      = 1'b0;
        gen_rx       = 1'b1;
        last_rx      = 8'h00;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("data_out", data_out, 16'h0000);
        check_value("serviced_read", 16'(serviced_read), 16'd0);
        check_value("led_out", {8'h00, led_out}, 16'h0000);
        check_value("tx", 16'(tx), 16'd1);
        expect_read("data_out status", mmio_pkg::UART_STATUS_ADDR, 16'h0000);
        test_led_path();
        test_loopback();
        test_address_forming();
        test_busy_rule();
        test_overrun();
        test_frame_error();
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Checks failed");
        end
    end

endmodule

`default_nettype wire

// File: project.f
hw/mmio_pkg.sv
hw/uart_pkg.sv
hw/periph_if.sv
hw/led_port.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_controller.sv
hw/mmio.sv
dv/mmio_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mmio_tb \
    -f project.f -o mmio_sim
./obj_dir/mmio_sim | tee sim.log
if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
